// ==== dv/calc_properties.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_properties (
    input logic                   clk,
    input logic                   nRST,
    input logic                   busy,
    input logic                   complete,
    input logic                   alu_start,
    input logic                   mult_start,
    input logic                   mult_finish,
    input logic [`CALC_WIDTH-1:0] display_output
);

    int assert_fails = 0;

    a_busy_complete: assert property (@(posedge clk) disable iff (!nRST)
        !(busy && complete))
        else begin
            assert_fails++;
            $error("busy and complete are high together");
        end

    a_one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mult_start))
        else begin
            assert_fails++;
            $error("alu_start and mult_start are high together");
        end

    a_mult_latency: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |-> ##(`CALC_WIDTH) mult_finish)
        else begin
            assert_fails++;
            $error("mult_finish did not follow mult_start after 16 cycles");
        end

    // Display only moves together with the rise of complete
    a_display_hold: assert property (@(posedge clk) disable iff (!nRST)
        $changed(display_output) |-> $rose(complete))
        else begin
            assert_fails++;
            $error("display_output changed outside a rising complete");
        end

endmodule

bind keypad_calculator calc_properties i_props (
    .clk            (clk),
    .nRST           (nRST),
    .busy           (busy),
    .complete       (complete),
    .alu_start      (alu_start),
    .mult_start     (mult_start),
    .mult_finish    (mult_finish),
    .display_output (display_output)
);

// ==== dv/calc_tb.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_tb;
    import calc_pkg::*;

    localparam int NUM_TESTS       = 25;        // Five directed and twenty random
    localparam int KEYS_PER_TEST   = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * KEYS_PER_TEST * 40 + 1000;
    localparam int WAIT_LIMIT      = 40;        // Cycles allowed per keypress
    localparam int ADD_LATENCY     = 4;         // Equal to complete, add or subtract
    localparam int MUL_LATENCY     = 19;        // Equal to complete, multiply

    logic                    clk;
    logic                    nRST;
    logic [`DIGIT_WIDTH-1:0] keypad_input;
    logic                    read_input;
    calc_op_t                operator_input;
    logic                    equal_input;
    logic                    busy;
    logic                    complete;
    logic [`CALC_WIDTH-1:0]  display_output;

    int                      mismatch_count = 0;
    int                      timeout_count  = 0;
    int                      total_errors;
    integer                  seed           = 98;
    int                      cycles;

    keypad_calculator i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_display(input logic [`CALC_WIDTH-1:0] exp);
        if (display_output !== exp) begin
            mismatch_count++;
            $display("Mismatch display_output: got 0x%04h expected 0x%04h", display_output, exp);
        end
    endtask

    task automatic check_operator(input calc_op_t exp);
        if (i_dut.latched_op !== exp) begin
            mismatch_count++;
            $display("Mismatch latched_op: got 0x%0h expected 0x%0h", i_dut.latched_op, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic exp);
        if (actual !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, actual, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int actual, input int exp);
        if (actual != exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, actual, exp);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            timeout_count++;
            $display("Timed out waiting for busy to fall");
        end
    endtask

    task automatic strobe_digit(input logic [`DIGIT_WIDTH-1:0] code);
        @(negedge clk);
        keypad_input = code;
        read_input   = 1'b1;
        @(negedge clk);
        read_input = 1'b0;                  // busy already visible here
    endtask

    task automatic press_digit(input logic [`DIGIT_WIDTH-1:0] code);
        strobe_digit(code);
        wait_idle();
    endtask

    task automatic press_operator(input calc_op_t op);
        @(negedge clk);
        operator_input = op;
        @(negedge clk);
        operator_input = OP_NONE;           // Level only held for one cycle
    endtask

    task automatic press_equal(output int latency);
        @(negedge clk);
        equal_input = 1'b1;
        latency = 0;
        while (!complete && latency < WAIT_LIMIT) begin
            @(negedge clk);
            equal_input = 1'b0;
            latency++;
        end
        equal_input = 1'b0;
        if (!complete) begin
            timeout_count++;
            $display("complete did not rise within %0d cycles of equal", WAIT_LIMIT);
        end
    endtask

    // Digits go in most significant first, model wraps on assignment
    task automatic enter_number(input int unsigned value, output logic [`CALC_WIDTH-1:0] model);
        int unsigned digits[$];
        int unsigned rest;
        rest = value;
        do begin
            digits.push_front(rest % `DECIMAL_BASE);
            rest = rest / `DECIMAL_BASE;
        end while (rest != 0);
        model = '0;
        foreach (digits[i]) begin
            press_digit(`DIGIT_WIDTH'(digits[i]));
            model = model * `DECIMAL_BASE + digits[i];
        end
    endtask

    task automatic run_calc(input int unsigned a, input calc_op_t op, input int unsigned b);
        logic [`CALC_WIDTH-1:0] model_a;
        logic [`CALC_WIDTH-1:0] model_b;
        logic [`CALC_WIDTH-1:0] exp;
        int                     latency;
        enter_number(a, model_a);
        check_flag("complete", complete, 1'b0);   // Previous result cleared
        press_operator(op);
        check_operator(op);
        enter_number(b, model_b);
        press_equal(latency);
        check_cycles("equal latency", latency, (op == OP_MUL) ? MUL_LATENCY : ADD_LATENCY);
        case (op)
            OP_ADD:  exp = model_a + model_b;
            OP_SUB:  exp = model_a - model_b;
            default: exp = model_a * model_b;
        endcase
        check_display(exp);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic test_ignored_inputs();
        int code;
        press_digit(4'd7);                   // Leaves the shown result
        for (code = 10; code < 16; code++) begin
            strobe_digit(`DIGIT_WIDTH'(code));
            check_flag("busy", busy, 1'b0);
        end
        press_operator(calc_op_t'(3'b011));
        check_operator(OP_MUL);              // Still the code from the multiply test
        @(negedge clk);
        equal_input = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
        check_flag("busy", busy, 1'b0);
        press_digit(4'd3);
        press_operator(OP_SUB);
        check_operator(OP_SUB);
        strobe_digit(4'd2);
        check_flag("busy", busy, 1'b1);
        strobe_digit(4'd9);                  // Dropped, controller busy
        wait_idle();
        press_digit(4'd5);
        press_equal(cycles);
        check_cycles("equal latency", cycles, ADD_LATENCY);
        check_display((7 * `DECIMAL_BASE + 3) - (2 * `DECIMAL_BASE + 5));
        check_operator(OP_SUB);
    endtask

    function automatic int unsigned random_operand();
        int unsigned value;
        int unsigned ndigits;
        value   = 0;
        ndigits = 1 + ({$random(seed)} % 5);
        repeat (ndigits) value = value * `DECIMAL_BASE + ({$random(seed)} % `DECIMAL_BASE);
        return value;
    endfunction

    task automatic test_random();
        int unsigned a;
        int unsigned b;
        calc_op_t    op;
        repeat (20) begin
            a = random_operand();
            b = random_operand();
            case ({$random(seed)} % 3)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                default: op = OP_MUL;
            endcase
            run_calc(a, op, b);
        end
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;

        check_flag("busy", busy, 1'b0);
        check_flag("complete", complete, 1'b0);
        check_display('0);

        run_calc(12, OP_ADD, 345);
        run_calc(5, OP_SUB, 9);
        run_calc(250, OP_MUL, 300);
        test_ignored_inputs();
        test_random();

        total_errors = mismatch_count + timeout_count + i_dut.i_props.assert_fails;
        $display("Errors: %0d (mismatches %0d, timeouts %0d, assertion failures %0d)",
                 total_errors, mismatch_count, timeout_count, i_dut.i_props.assert_fails);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/calc_pkg.sv
verilog/add_sub_unit.sv
verilog/shift_add_multiplier.sv
verilog/operand_regs.sv
verilog/calc_controller.sv
verilog/keypad_calculator.sv
dv/calc_properties.sv
dv/calc_tb.sv

// ==== verilog/add_sub_unit.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module add_sub_unit (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [`CALC_WIDTH-1:0] in_a,
    input  logic [`CALC_WIDTH-1:0] in_b,
    input  logic                   sub,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);

    // Result registered on start, wraps modulo 2^16
    always_ff @(posedge clk) begin
        if (start) begin
            if (sub) begin
                out <= in_a - in_b;     // Two's complement low bits
            end else begin
                out <= in_a + in_b;
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;            // One cycle latency
        end
    end

endmodule

// ==== verilog/calc_controller.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_controller (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [`DIGIT_WIDTH-1:0] keypad_input,
    input  logic                    read_input,
    input  calc_pkg::calc_op_t      operator_input,
    input  logic                    equal_input,
    input  logic [`CALC_WIDTH-1:0]  operand1,
    input  logic [`CALC_WIDTH-1:0]  operand2,
    input  calc_pkg::calc_op_t      latched_op,
    input  logic                    alu_finish,
    input  logic                    mult_finish,
    output logic [`CALC_WIDTH-1:0]  alu_a,
    output logic [`CALC_WIDTH-1:0]  alu_b,
    output logic [`CALC_WIDTH-1:0]  mult_a,
    output logic [`CALC_WIDTH-1:0]  mult_b,
    output logic                    alu_sub,
    output logic                    alu_start,
    output logic                    mult_start,
    output logic                    load_op1,
    output logic                    load_op2,
    output logic                    clear_op1,
    output logic                    clear_op2,
    output logic                    load_operator,
    output logic                    load_display,
    output logic                    result_from_mult,
    output logic                    busy,
    output logic                    complete
);
    import calc_pkg::*;

    calc_state_t             state, next_state;
    logic                    op2_active;      // Digits go to operand 2
    logic [`DIGIT_WIDTH-1:0] digit_q;
    logic                    idle;
    logic                    accept_digit, accept_op;
    logic                    evaluating, is_mul;
    logic                    scale_done, digit_done;
    logic [`CALC_WIDTH-1:0]  active_operand;

    assign idle = (state inside {ENTER_OP1, ENTER_OP2, SHOW_RESULT});

    // Codes at or above the base are not digits
    assign accept_digit = idle && read_input &&
                          (keypad_input < `DIGIT_WIDTH'(`DECIMAL_BASE));
    assign accept_op    = (state == ENTER_OP1) && !read_input &&
                          (operator_input inside {OP_ADD, OP_SUB, OP_MUL});

    assign evaluating = (state inside {EVAL_START, EVAL_WAIT});
    assign is_mul     = (latched_op == OP_MUL);
    assign scale_done = (state == SCALE_WAIT) && mult_finish;
    assign digit_done = (state == DIGIT_WAIT) && alu_finish;

    always_comb begin
        next_state = state;
        case (state)
            ENTER_OP1: begin
                if (accept_digit) begin
                    next_state = SCALE_START;
                end else if (accept_op) begin
                    next_state = ENTER_OP2;
                end
            end
            ENTER_OP2: begin
                if (accept_digit) begin
                    next_state = SCALE_START;
                end else if (equal_input) begin
                    next_state = EVAL_START;
                end
            end
            SHOW_RESULT: begin
                if (accept_digit) begin
                    next_state = SCALE_START;  // Fresh calculation
                end
            end
            SCALE_START: next_state = SCALE_WAIT;
            SCALE_WAIT: begin
                if (mult_finish) begin
                    next_state = DIGIT_START;
                end
            end
            DIGIT_START: next_state = DIGIT_WAIT;
            DIGIT_WAIT: begin
                if (alu_finish) begin
                    next_state = op2_active ? ENTER_OP2 : ENTER_OP1;
                end
            end
            EVAL_START: next_state = EVAL_WAIT;
            EVAL_WAIT: begin
                if (is_mul ? mult_finish : alu_finish) begin
                    next_state = SHOW_RESULT;
                end
            end
            default: next_state = ENTER_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ENTER_OP1;
            op2_active <= 1'b0;
            alu_start  <= 1'b0;
            mult_start <= 1'b0;
        end else begin
            state <= next_state;
            if (accept_op) begin
                op2_active <= 1'b1;
            end else if (accept_digit && state == SHOW_RESULT) begin
                op2_active <= 1'b0;
            end
            // Starts leave one cycle after the START state
            alu_start  <= (state == DIGIT_START) || (state == EVAL_START && !is_mul);
            mult_start <= (state == SCALE_START) || (state == EVAL_START && is_mul);
        end
    end

    always_ff @(posedge clk) begin
        if (accept_digit) begin
            digit_q <= keypad_input;
        end
    end

    // Operand muxes stay stable through START and WAIT
    assign active_operand = op2_active ? operand2 : operand1;
    assign alu_a  = evaluating ? operand1 : active_operand;
    assign alu_b  = evaluating ? operand2 :
                    {{(`CALC_WIDTH - `DIGIT_WIDTH){1'b0}}, digit_q};
    assign mult_a = evaluating ? operand1 : active_operand;
    assign mult_b = evaluating ? operand2 : `CALC_WIDTH'(`DECIMAL_BASE);
    assign alu_sub = evaluating && (latched_op == OP_SUB);

    // Register strobes
    assign result_from_mult = (state == SCALE_WAIT) || (evaluating && is_mul);
    assign load_op1      = (scale_done || digit_done) && !op2_active;
    assign load_op2      = (scale_done || digit_done) && op2_active;
    assign clear_op1     = accept_digit && (state == SHOW_RESULT);
    assign clear_op2     = accept_op;
    assign load_operator = accept_op;
    assign load_display  = (state == EVAL_WAIT) && (is_mul ? mult_finish : alu_finish);

    assign busy     = !idle;
    assign complete = (state == SHOW_RESULT);

endmodule

// ==== verilog/calc_params.svh ====
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// Operand, result and display width
`define CALC_WIDTH 16

// Keypad code width
`define DIGIT_WIDTH 4

// Base for digit entry, each new digit scales the operand by this
`define DECIMAL_BASE 10

`endif

// ==== verilog/calc_pkg.sv ====
package calc_pkg;

    // Operator codes, one-hot as they come from the keypad
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } calc_op_t;

    // Controller sequence
    typedef enum logic [3:0] {
        ENTER_OP1   = 4'd0,  // Waiting for first operand input
        ENTER_OP2   = 4'd1,  // Waiting for second operand input
        SCALE_START = 4'd2,  // Kick off operand times ten
        SCALE_WAIT  = 4'd3,
        DIGIT_START = 4'd4,  // Kick off digit add
        DIGIT_WAIT  = 4'd5,
        EVAL_START  = 4'd6,  // Kick off the requested operation
        EVAL_WAIT   = 4'd7,
        SHOW_RESULT = 4'd8   // Result on display
    } calc_state_t;

endpackage

// ==== verilog/keypad_calculator.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module keypad_calculator (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [`DIGIT_WIDTH-1:0] keypad_input,
    input  logic                    read_input,
    input  calc_pkg::calc_op_t      operator_input,
    input  logic                    equal_input,
    output logic                    busy,
    output logic                    complete,
    output logic [`CALC_WIDTH-1:0]  display_output
);
    import calc_pkg::*;

    logic [`CALC_WIDTH-1:0] alu_a, alu_b, alu_out;
    logic [`CALC_WIDTH-1:0] mult_a, mult_b, mult_out;
    logic                   alu_sub, alu_start, alu_finish;
    logic                   mult_start, mult_finish;
    logic [`CALC_WIDTH-1:0] operand1, operand2;
    calc_op_t               latched_op;
    logic                   load_op1, load_op2, clear_op1, clear_op2;
    logic                   load_operator, load_display, result_from_mult;

    calc_controller i_controller (
        .clk              (clk),
        .nRST             (nRST),
        .keypad_input     (keypad_input),
        .read_input       (read_input),
        .operator_input   (operator_input),
        .equal_input      (equal_input),
        .operand1         (operand1),
        .operand2         (operand2),
        .latched_op       (latched_op),
        .alu_finish       (alu_finish),
        .mult_finish      (mult_finish),
        .alu_a            (alu_a),
        .alu_b            (alu_b),
        .mult_a           (mult_a),
        .mult_b           (mult_b),
        .alu_sub          (alu_sub),
        .alu_start        (alu_start),
        .mult_start       (mult_start),
        .load_op1         (load_op1),
        .load_op2         (load_op2),
        .clear_op1        (clear_op1),
        .clear_op2        (clear_op2),
        .load_operator    (load_operator),
        .load_display     (load_display),
        .result_from_mult (result_from_mult),
        .busy             (busy),
        .complete         (complete)
    );

    operand_regs i_regs (
        .clk              (clk),
        .nRST             (nRST),
        .alu_out          (alu_out),
        .mult_out         (mult_out),
        .load_op1         (load_op1),
        .load_op2         (load_op2),
        .clear_op1        (clear_op1),
        .clear_op2        (clear_op2),
        .load_operator    (load_operator),
        .load_display     (load_display),
        .result_from_mult (result_from_mult),
        .operator_input   (operator_input),
        .operand1         (operand1),
        .operand2         (operand2),
        .latched_op       (latched_op),
        .display_output   (display_output)
    );

    add_sub_unit i_alu (
        .clk    (clk),
        .nRST   (nRST),
        .in_a   (alu_a),
        .in_b   (alu_b),
        .sub    (alu_sub),
        .start  (alu_start),
        .out    (alu_out),
        .finish (alu_finish)
    );

    shift_add_multiplier i_mult (
        .clk    (clk),
        .nRST   (nRST),
        .in_a   (mult_a),
        .in_b   (mult_b),
        .start  (mult_start),
        .out    (mult_out),
        .finish (mult_finish)
    );

endmodule

// ==== verilog/operand_regs.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module operand_regs (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [`CALC_WIDTH-1:0] alu_out,
    input  logic [`CALC_WIDTH-1:0] mult_out,
    input  logic                   load_op1,
    input  logic                   load_op2,
    input  logic                   clear_op1,
    input  logic                   clear_op2,
    input  logic                   load_operator,
    input  logic                   load_display,
    input  logic                   result_from_mult,
    input  calc_pkg::calc_op_t     operator_input,
    output logic [`CALC_WIDTH-1:0] operand1,
    output logic [`CALC_WIDTH-1:0] operand2,
    output calc_pkg::calc_op_t     latched_op,
    output logic [`CALC_WIDTH-1:0] display_output
);
    import calc_pkg::*;

    logic [`CALC_WIDTH-1:0] result;

    // One result bus feeds every register
    assign result = result_from_mult ? mult_out : alu_out;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand1       <= '0;
            operand2       <= '0;
            latched_op     <= OP_NONE;
            display_output <= '0;
        end else begin
            if (clear_op1) begin
                operand1 <= '0;         // New calculation wins over load
            end else if (load_op1) begin
                operand1 <= result;
            end

            if (clear_op2) begin
                operand2 <= '0;
            end else if (load_op2) begin
                operand2 <= result;
            end

            if (load_operator) begin
                latched_op <= operator_input;
            end

            if (load_display) begin
                display_output <= result;
            end
        end
    end

endmodule

// ==== verilog/shift_add_multiplier.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module shift_add_multiplier (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [`CALC_WIDTH-1:0] in_a,
    input  logic [`CALC_WIDTH-1:0] in_b,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);

    localparam int CNT_W = $clog2(`CALC_WIDTH);

    logic [`CALC_WIDTH-1:0] mcand;      // Shifted left each step
    logic [`CALC_WIDTH-1:0] mplier;     // Shifted right each step
    logic [`CALC_WIDTH-1:0] acc;
    logic [CNT_W-1:0]       bit_cnt;    // Bit examined on the next edge
    logic                   running;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                bit_cnt <= CNT_W'(1);   // Bit 0 handled at load
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`CALC_WIDTH - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // Only the low word of the product is kept
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= in_a << 1;
            mplier <= in_b >> 1;
            acc    <= in_b[0] ? in_a : '0;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign out = acc;                   // Holds until the next start

endmodule
